// File: hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////
    // widths and fixed indices
    //////////////////////////////
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int NumRegs      = 32;
    localparam int LinkReg      = 31;    // jal destination
    localparam int JumpShadow   = 3;     // instrs squashed after a jump

    //////////////////////////////
    // encodings
    //////////////////////////////

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,   // R-type, see funct
        OpJ       = 6'h02,
        OpJal     = 6'h03,
        OpAddi    = 6'h08,
        OpAddiu   = 6'h09,
        OpSlti    = 6'h0A,
        OpAndi    = 6'h0C,
        OpOri     = 6'h0D,
        OpXori    = 6'h0E,
        OpLui     = 6'h0F
    } opcode_e;

    // R-type function, instr[5:0]
    typedef enum logic [5:0] {
        FnSll  = 6'h00,
        FnSrl  = 6'h02,
        FnJr   = 6'h08,
        FnAdd  = 6'h20,
        FnAddu = 6'h21,
        FnSub  = 6'h22,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnXor  = 6'h26,
        FnSlt  = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSll,
        AluSrl,
        AluLui,
        AluLink     // pc + 8 for jal
    } aluOp_e;

    typedef enum logic [1:0] {
        JmpNone,
        JmpDirect,  // j, jal
        JmpReg      // jr
    } jumpKind_e;

    //////////////////////////////
    // pipeline bundles
    //////////////////////////////
    typedef struct packed {
        aluOp_e                  aluOp;
        logic                    regWrite;
        logic                    useImm;    // operand b from imm
        jumpKind_e               jumpKind;
        logic [RegAddrWidth-1:0] dest;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [DataWidth-1:0]    pc;
        logic [RegAddrWidth-1:0] rsIdx;
        logic [RegAddrWidth-1:0] rtIdx;
        logic [DataWidth-1:0]    rsVal;     // file value, may be stale
        logic [DataWidth-1:0]    rtVal;
        logic [DataWidth-1:0]    imm;       // already extended
        logic [4:0]              shamt;
        logic [25:0]             jumpIndex;
    } idEx_t;

    typedef struct packed {
        logic [RegAddrWidth-1:0] dest;
        logic [DataWidth-1:0]    data;
    } exResult_t;

endpackage

`default_nettype wire

// File: hdl/controlDecoder.sv
`default_nettype none

module controlDecoder (
    input  wire logic [31:0] instr,
    output mipsPkg::ctrl_t   ctrl,
    output logic [31:0]      imm,
    output logic [4:0]       shamt,
    output logic [25:0]      jumpIndex
);
    import mipsPkg::*;

    logic zeroExt;   // andi/ori/xori take unsigned imm

    assign shamt     = instr[10:6];
    assign jumpIndex = instr[25:0];

    //////////////////////////////
    // control fields
    //////////////////////////////
    always_comb begin
        ctrl          = '0;          // unknown codes end up as no-op
        ctrl.aluOp    = AluAdd;
        ctrl.jumpKind = JmpNone;
        ctrl.dest     = instr[20:16];   // rt for I-type
        zeroExt       = 1'b0;

        case (opcode_e'(instr[31:26]))
            OpSpecial: begin
                ctrl.dest     = instr[15:11];   // rd
                ctrl.regWrite = 1'b1;
                case (funct_e'(instr[5:0]))
                    FnAdd, FnAddu: ctrl.aluOp = AluAdd;   // no overflow trap
                    FnSub, FnSubu: ctrl.aluOp = AluSub;
                    FnAnd:         ctrl.aluOp = AluAnd;
                    FnOr:          ctrl.aluOp = AluOr;
                    FnXor:         ctrl.aluOp = AluXor;
                    FnSlt:         ctrl.aluOp = AluSlt;
                    FnSll:         ctrl.aluOp = AluSll;
                    FnSrl:         ctrl.aluOp = AluSrl;
                    FnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpKind = JmpReg;
                    end
                    default: ctrl.regWrite = 1'b0;    // unknown funct
                endcase
            end
            OpJ: ctrl.jumpKind = JmpDirect;
            OpJal: begin
                ctrl.jumpKind = JmpDirect;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = AluLink;
                ctrl.dest     = RegAddrWidth'(LinkReg);
            end
            OpAddi, OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.useImm   = 1'b1;
                case (opcode_e'(instr[31:26]))
                    OpSlti:  ctrl.aluOp = AluSlt;
                    OpAndi:  ctrl.aluOp = AluAnd;
                    OpOri:   ctrl.aluOp = AluOr;
                    OpXori:  ctrl.aluOp = AluXor;
                    OpLui:   ctrl.aluOp = AluLui;
                    default: ctrl.aluOp = AluAdd;    // addi, addiu
                endcase
                // logical forms are zero extended
                zeroExt = (opcode_e'(instr[31:26]) inside {OpAndi, OpOri, OpXori});
            end
            default: ;   // unknown opcode, defaults stand
        endcase
    end

    // immediate extension
    assign imm = zeroExt ? {16'b0, instr[15:0]}
                         : {{16{instr[15]}}, instr[15:0]};

endmodule

`default_nettype wire

// File: hdl/registerFile.sv
`default_nettype none

module registerFile (
    input  wire logic                         Clk,
    input  wire logic                         Reset,
    input  wire logic [mipsPkg::RegAddrWidth-1:0] rsIdx,
    input  wire logic [mipsPkg::RegAddrWidth-1:0] rtIdx,
    output logic [mipsPkg::DataWidth-1:0]     rsVal,
    output logic [mipsPkg::DataWidth-1:0]     rtVal,
    input  wire logic                         wrEn,
    input  wire mipsPkg::exResult_t           wrRes
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [NumRegs];

    // write port, written from the execute result register
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrRes.dest != '0) begin
            regs[wrRes.dest] <= wrRes.data;
        end
    end

    // combinational reads, r0 hardwired
    // a write in flight reads through, so the file looks written one edge earlier
    assign rsVal = (rsIdx == '0)                ? '0
                 : (wrEn && wrRes.dest == rsIdx) ? wrRes.data
                 : regs[rsIdx];
    assign rtVal = (rtIdx == '0)                ? '0
                 : (wrEn && wrRes.dest == rtIdx) ? wrRes.data
                 : regs[rtIdx];

    // execute stage never strobes a result for r0
    a_noWriteR0 : assert property (@(posedge Clk) disable iff (Reset)
        wrEn |-> wrRes.dest != '0)
        else $error("register file write to r0");

endmodule

`default_nettype wire

// File: hdl/idExRegister.sv
`default_nettype none

module idExRegister (
    input  wire logic           Clk,
    input  wire logic           Reset,
    input  wire logic           inValid,
    input  wire logic           Flush,
    input  wire mipsPkg::idEx_t inStage,
    output logic                stageValid,
    output mipsPkg::idEx_t      stage
);
    import mipsPkg::*;

    localparam int CntWidth = $clog2(JumpShadow + 1);

    logic [CntWidth-1:0] squashCnt;   // valid instrs still to drop
    logic                isJump;

    assign isJump = (inStage.ctrl.jumpKind != JmpNone);

    //////////////////////////////
    // stage register + jump shadow
    //////////////////////////////
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            stageValid <= 1'b0;
            stage      <= '0;
            squashCnt  <= '0;
        end else if (Flush) begin
            // drop the sampled instr, cancel pending squash
            stageValid <= 1'b0;
            stage      <= '0;
            squashCnt  <= '0;
        end else if (inValid && squashCnt != '0) begin
            stageValid <= 1'b0;              // in the jump shadow
            stage      <= '0;
            squashCnt  <= squashCnt - 1'b1;
        end else if (inValid) begin
            stageValid <= 1'b1;
            stage      <= inStage;
            if (isJump) begin
                squashCnt <= CntWidth'(JumpShadow);
            end
        end else begin
            stageValid <= 1'b0;              // idle, count holds
            stage      <= '0;
        end
    end

    a_squashBound : assert property (@(posedge Clk) disable iff (Reset)
        squashCnt <= CntWidth'(JumpShadow))
        else $error("squash count out of range: %0d", squashCnt);

endmodule

`default_nettype wire

// File: hdl/executeUnit.sv
`default_nettype none

module executeUnit (
    input  wire logic                     Clk,
    input  wire logic                     Reset,
    input  wire logic                     stageValid,
    input  wire mipsPkg::idEx_t           stage,
    output logic                          resValid,
    output mipsPkg::exResult_t            res,
    output logic                          jumpValid,
    output logic [mipsPkg::DataWidth-1:0] jumpTarget
);
    import mipsPkg::*;

    logic [DataWidth-1:0] rsFwd;        // operands after forwarding
    logic [DataWidth-1:0] rtFwd;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluOut;
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] target;
    logic                 writes;
    logic                 jumps;

    //////////////////////////////
    // forwarding
    //////////////////////////////
    // producer one cycle ahead is still in res, file not yet visible
    assign rsFwd = (resValid && stage.rsIdx != '0 && res.dest == stage.rsIdx)
                 ? res.data : stage.rsVal;
    assign rtFwd = (resValid && stage.rtIdx != '0 && res.dest == stage.rtIdx)
                 ? res.data : stage.rtVal;

    assign opB     = stage.ctrl.useImm ? stage.imm : rtFwd;
    assign pcPlus4 = stage.pc + 32'd4;

    //////////////////////////////
    // alu
    //////////////////////////////
    always_comb begin
        case (stage.ctrl.aluOp)
            AluAdd:  aluOut = rsFwd + opB;
            AluSub:  aluOut = rsFwd - opB;
            AluAnd:  aluOut = rsFwd & opB;
            AluOr:   aluOut = rsFwd | opB;
            AluXor:  aluOut = rsFwd ^ opB;
            AluSlt:  aluOut = {{(DataWidth-1){1'b0}}, $signed(rsFwd) < $signed(opB)};
            AluSll:  aluOut = rtFwd << stage.shamt;   // shifts act on rt
            AluSrl:  aluOut = rtFwd >> stage.shamt;
            AluLui:  aluOut = stage.imm << 16;
            AluLink: aluOut = stage.pc + 32'd8;       // return addr
            default: aluOut = '0;
        endcase
    end

    // jump target, region of pc+4 for j/jal
    always_comb begin
        case (stage.ctrl.jumpKind)
            JmpDirect: target = {pcPlus4[31:28], stage.jumpIndex, 2'b00};
            JmpReg:    target = rsFwd;
            default:   target = '0;
        endcase
    end

    assign writes = stageValid && stage.ctrl.regWrite && stage.ctrl.dest != '0;
    assign jumps  = stageValid && stage.ctrl.jumpKind != JmpNone;

    //////////////////////////////
    // result register
    //////////////////////////////
    always_ff @(posedge Clk or posedge Reset) begin
        if (Reset) begin
            resValid   <= 1'b0;
            res        <= '0;
            jumpValid  <= 1'b0;
            jumpTarget <= '0;
        end else begin
            resValid  <= writes;        // r0 writes dropped here
            jumpValid <= jumps;
            if (writes) begin
                res.dest <= stage.ctrl.dest;
                res.data <= aluOut;
            end
            if (jumps) begin
                jumpTarget <= target;
            end
        end
    end

    // a result strobe comes from a valid stage one cycle back
    a_resDest : assert property (@(posedge Clk) disable iff (Reset)
        resValid |-> res.dest != '0 && $past(stageValid))
        else $error("result strobe with dest %0d", res.dest);

endmodule

`default_nettype wire

// File: hdl/decodeExecute.sv
`default_nettype none

module decodeExecute (
    input  wire logic                     Clk,
    input  wire logic                     Reset,
    input  wire logic                     instrValid,
    input  wire logic [31:0]              instr,
    input  wire logic [31:0]              pc,
    input  wire logic                     Flush,
    output logic                          resValid,
    output mipsPkg::exResult_t            res,
    output logic                          jumpValid,
    output logic [mipsPkg::DataWidth-1:0] jumpTarget
);
    import mipsPkg::*;

    ctrl_t                decCtrl;
    logic [DataWidth-1:0] decImm;
    logic [4:0]           decShamt;
    logic [25:0]          decJumpIndex;
    logic [DataWidth-1:0] rsVal;
    logic [DataWidth-1:0] rtVal;
    idEx_t                decoded;    // bundle into ID/EX
    idEx_t                stage;
    logic                 stageValid;

    //////////////////////////////
    // decode
    //////////////////////////////
    controlDecoder controlDecoder_inst (
        .instr     (instr),
        .ctrl      (decCtrl),
        .imm       (decImm),
        .shamt     (decShamt),
        .jumpIndex (decJumpIndex)
    );

    // written back from the execute result register
    registerFile registerFile_inst (
        .Clk   (Clk),
        .Reset (Reset),
        .rsIdx (instr[25:21]),
        .rtIdx (instr[20:16]),
        .rsVal (rsVal),
        .rtVal (rtVal),
        .wrEn  (resValid),
        .wrRes (res)
    );

    assign decoded = '{
        ctrl:      decCtrl,
        pc:        pc,
        rsIdx:     instr[25:21],
        rtIdx:     instr[20:16],
        rsVal:     rsVal,
        rtVal:     rtVal,
        imm:       decImm,
        shamt:     decShamt,
        jumpIndex: decJumpIndex
    };

    //////////////////////////////
    // ID/EX and execute
    //////////////////////////////
    idExRegister idExRegister_inst (
        .Clk        (Clk),
        .Reset      (Reset),
        .inValid    (instrValid),
        .Flush      (Flush),
        .inStage    (decoded),
        .stageValid (stageValid),
        .stage      (stage)
    );

    executeUnit executeUnit_inst (
        .Clk        (Clk),
        .Reset      (Reset),
        .stageValid (stageValid),
        .stage      (stage),
        .resValid   (resValid),
        .res        (res),
        .jumpValid  (jumpValid),
        .jumpTarget (jumpTarget)
    );

endmodule

`default_nettype wire

// File: tb/resultChecker.sv
`default_nettype none

module resultChecker (
    input  wire logic               Clk,
    input  wire logic               Reset,
    input  wire logic               instrValid,
    input  wire logic [31:0]        instr,
    input  wire logic [31:0]        pc,
    input  wire logic               Flush,
    input  wire logic               resValid,
    input  wire mipsPkg::exResult_t res,
    input  wire logic               jumpValid,
    input  wire logic [31:0]        jumpTarget,
    output int                      errorCount,
    output int                      checkCount,
    output int                      pending
);
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    // one executed instr, as the outputs should show it
    typedef struct {
        int          due;       // cycle at which the strobe is sampled
        logic        wr;
        logic [4:0]  dest;
        logic [31:0] data;
        logic        jmp;
        logic [31:0] target;
    } outcome_t;

    logic [31:0] archRegs [32];     // architectural state, in program order
    int          squashLeft;
    int          cycle = 0;
    int          pushCount = 0;
    int          popCount = 0;
    outcome_t    expected [$];

    assign pending = pushCount - popCount;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic outcome_t executeRef(input logic [31:0] word, input logic [31:0] pcVal,
                                            input logic [31:0] a, input logic [31:0] b);
        outcome_t    o;
        logic [31:0] sImm;
        logic [31:0] zImm;
        logic [31:0] pc4;
        sImm     = {{16{word[15]}}, word[15:0]};
        zImm     = {16'h0000, word[15:0]};
        pc4      = pcVal + 32'd4;
        o.due    = 0;
        o.wr     = 1'b1;
        o.dest   = word[20:16];     // rt unless R-type or jal
        o.data   = '0;
        o.jmp    = 1'b0;
        o.target = '0;
        case (word[31:26])
            6'h00: begin            // special, decoded by funct
                o.dest = word[15:11];
                case (word[5:0])
                    6'h20, 6'h21: o.data = a + b;
                    6'h22, 6'h23: o.data = a - b;
                    6'h24:        o.data = a & b;
                    6'h25:        o.data = a | b;
                    6'h26:        o.data = a ^ b;
                    6'h2A:        o.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00:        o.data = b << word[10:6];    // sll on rt
                    6'h02:        o.data = b >> word[10:6];
                    6'h08: begin                               // jr
                        o.wr     = 1'b0;
                        o.jmp    = 1'b1;
                        o.target = a;
                    end
                    default:      o.wr = 1'b0;
                endcase
            end
            6'h02: begin            // j
                o.wr     = 1'b0;
                o.jmp    = 1'b1;
                o.target = {pc4[31:28], word[25:0], 2'b00};
            end
            6'h03: begin            // jal, link into r31
                o.jmp    = 1'b1;
                o.target = {pc4[31:28], word[25:0], 2'b00};
                o.dest   = 5'd31;
                o.data   = pcVal + 32'd8;
            end
            6'h08, 6'h09: o.data = a + sImm;
            6'h0A:        o.data = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            6'h0C:        o.data = a & zImm;
            6'h0D:        o.data = a | zImm;
            6'h0E:        o.data = a ^ zImm;
            6'h0F:        o.data = {word[15:0], 16'h0000};   // lui
            default:      o.wr = 1'b0;                       // unknown, no-op
        endcase
        if (o.dest == 5'd0) begin
            o.wr = 1'b0;            // r0 writes never strobe
        end
        return o;
    endfunction

    // input side, runs the model on every sampled instr
    always @(posedge Clk) begin : modelProcess
        outcome_t o;
        if (Reset) begin
            for (int i = 0; i < 32; i++) begin
                archRegs[i] = '0;
            end
            squashLeft = 0;
            pushCount  = 0;
            expected.delete();
        end else if (Flush) begin
            squashLeft = 0;         // sampled instr dropped too
        end else if (instrValid && squashLeft != 0) begin
            squashLeft--;           // jump shadow
        end else if (instrValid) begin
            o     = executeRef(instr, pc, archRegs[instr[25:21]], archRegs[instr[20:16]]);
            o.due = cycle + 2;      // two edges of latency
            if (o.wr) begin
                archRegs[o.dest] = o.data;
            end
            if (o.jmp) begin
                squashLeft = JumpShadow;
            end
            if (o.wr || o.jmp) begin
                expected.push_back(o);
                pushCount++;
            end
        end
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // comparison
    //////////////////////////////
    task automatic compareHex(input string name, input logic [31:0] want, input logic [31:0] got);
        checkCount++;
        if (want !== got) begin
            errorCount++;
            $display("error: %s expected %h got %h at cycle %0d", name, want, got, cycle);
        end
    endtask

    task automatic reportFailure(input string msg);
        errorCount++;
        $display("%s at cycle %0d", msg, cycle);
    endtask

    always @(posedge Clk) begin : compareProcess
        outcome_t e;
        if (Reset) begin
            popCount = 0;
            if (resValid || jumpValid) begin
                reportFailure("unexpected strobe while in reset");
            end
        end else begin
            e.wr  = 1'b0;
            e.jmp = 1'b0;
            if (expected.size() != 0 && expected[0].due == cycle) begin
                e = expected.pop_front();
                popCount++;
            end
            // result side
            if (e.wr && !resValid) begin
                reportFailure($sformatf("missing result for register %0d", e.dest));
            end else if (!e.wr && resValid) begin
                reportFailure($sformatf("unexpected strobe on result for register %0d",
                                        res.dest));
            end else if (e.wr) begin
                compareHex("res.dest", 32'(e.dest), 32'(res.dest));
                compareHex("res.data", e.data, res.data);
            end
            // jump side
            if (e.jmp && !jumpValid) begin
                reportFailure("missing jump, no strobe on jumpValid");
            end else if (!e.jmp && jumpValid) begin
                reportFailure("unexpected strobe on jumpValid");
            end else if (e.jmp) begin
                compareHex("jumpTarget", e.target, jumpTarget);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tbDecodeExecute.sv
`default_nettype none

module tbDecodeExecute;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    localparam int ResetCycles  = 16;
    localparam int DrainTimeout = 50;     // cycles
    localparam int RandomCount  = 300;

    logic        Clk = 1'b0;
    logic        Reset;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        Flush;
    logic        resValid;
    exResult_t   res;
    logic        jumpValid;
    logic [31:0] jumpTarget;
    int          errorCount;
    int          checkCount;
    int          pending;
    int          testNum;
    int          lastErrors;
    logic [31:0] nextPc;

    funct_e  rFuncs [10] = '{FnAdd, FnAddu, FnSub, FnSubu, FnAnd,
                             FnOr, FnXor, FnSlt, FnSll, FnSrl};
    opcode_e iOps [7]    = '{OpAddi, OpAddiu, OpSlti, OpAndi, OpOri, OpXori, OpLui};

    always #20 Clk = ~Clk;    // 40 ns period

    decodeExecute decodeExecute_inst (
        .Clk(Clk), .Reset(Reset), .instrValid(instrValid), .instr(instr), .pc(pc),
        .Flush(Flush), .resValid(resValid), .res(res), .jumpValid(jumpValid),
        .jumpTarget(jumpTarget)
    );

    resultChecker resultChecker_inst (
        .Clk(Clk), .Reset(Reset), .instrValid(instrValid), .instr(instr), .pc(pc),
        .Flush(Flush), .resValid(resValid), .res(res), .jumpValid(jumpValid),
        .jumpTarget(jumpTarget), .errorCount(errorCount), .checkCount(checkCount),
        .pending(pending)
    );

    //////////////////////////////
    // encoders and drivers
    //////////////////////////////
    function automatic logic [31:0] rType(funct_e fn, int rs, int rt, int rd, int sh);
        return {OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [31:0] iType(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] randomInstr();
        int kind;
        kind = $urandom_range(19, 0);
        if (kind < 9) begin
            return rType(rFuncs[$urandom_range(9, 0)], $urandom_range(31, 0),
                         $urandom_range(31, 0), $urandom_range(31, 0), $urandom_range(31, 0));
        end else if (kind < 17) begin
            return iType(iOps[$urandom_range(6, 0)], $urandom_range(31, 0),
                         $urandom_range(31, 0), 16'($urandom()));
        end else if (kind == 17) begin
            return {($urandom_range(1, 0) == 0) ? OpJ : OpJal, 26'($urandom())};
        end else if (kind == 18) begin
            return rType(FnJr, $urandom_range(31, 0), 0, 0, 0);
        end
        return {6'h3F, 26'($urandom())};     // unknown opcode
    endfunction

    task automatic sendInstr(input logic [31:0] word, input logic flushIt);
        @(posedge Clk);
        instrValid <= 1'b1;
        instr      <= word;
        pc         <= nextPc;
        Flush      <= flushIt;
        nextPc     = nextPc + 32'd4;
    endtask

    task automatic gapCycles(input int n);
        repeat (n) begin
            @(posedge Clk);
            instrValid <= 1'b0;
            Flush      <= 1'b0;
        end
    endtask

    task automatic loadReg(input int r, input logic [31:0] value);
        sendInstr(iType(OpLui, 0, r, value[31:16]), 1'b0);
        sendInstr(iType(OpOri, r, r, value[15:0]), 1'b0);
    endtask

    // waits for every expected strobe to be compared
    task automatic drainPipeline();
        int waited;
        gapCycles(1);
        waited = 0;
        @(negedge Clk);
        while (pending != 0) begin
            waited++;
            if (waited > DrainTimeout) begin
                $display("timeout, expected results still pending after %0d cycles", waited);
                $display("Test FAILED");
                $finish;
            end
            @(negedge Clk);
        end
    endtask

    task automatic finishTest(input string name);
        drainPipeline();
        gapCycles(2);             // late strobes still get caught
        @(negedge Clk);
        $display("test %0d %s done, %0d errors", testNum, name, errorCount - lastErrors);
        lastErrors = errorCount;
        testNum++;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////
    initial begin
        void'($urandom(90));
        Reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        Flush      = 1'b0;
        nextPc     = 32'h0040_0000;
        testNum    = 1;
        lastErrors = 0;
        repeat (ResetCycles) @(posedge Clk);
        Reset <= 1'b0;

        // reset state, every register ori'd with 0
        gapCycles(4);
        for (int i = 0; i < 32; i++) begin
            sendInstr(iType(OpOri, i, i, 16'h0000), 1'b0);
        end
        finishTest("reset state");

        for (int r = 1; r <= 8; r++) begin
            loadReg(r, $urandom());
        end
        for (int n = 0; n < 40; n++) begin
            sendInstr(rType(rFuncs[$urandom_range(9, 0)], $urandom_range(8, 1),
                            $urandom_range(8, 1), $urandom_range(31, 9),
                            $urandom_range(31, 0)), 1'b0);
        end
        finishTest("r-type alu");

        for (int n = 0; n < 40; n++) begin
            sendInstr(iType(iOps[$urandom_range(6, 0)], $urandom_range(8, 1),
                            $urandom_range(31, 9), 16'($urandom())), 1'b0);
        end
        finishTest("immediates");

        // dependency chain, gaps of 0, 1 and 2
        for (int g = 0; g < 3; g++) begin
            sendInstr(iType(OpAddi, 0, 1, 16'(100 + g)), 1'b0);
            gapCycles(g);
            sendInstr(iType(OpAddi, 1, 2, 16'h0005), 1'b0);
            gapCycles(g);
            sendInstr(rType(FnSub, 2, 1, 3, 0), 1'b0);
            gapCycles(g);
            sendInstr(iType(OpAddi, 3, 0, 16'h0001), 1'b0);   // r0, no strobe
            gapCycles(g);
            sendInstr(rType(FnOr, 0, 3, 4, 0), 1'b0);
            gapCycles(g);
        end
        finishTest("dependencies");

        loadReg(5, 32'h0040_1000);
        sendInstr({OpJ, 26'h010_0400}, 1'b0);
        for (int k = 0; k < 4; k++) begin
            sendInstr(iType(OpAddi, 6, 6, 16'h0001), 1'b0);   // first three squashed
            gapCycles(k);
        end
        sendInstr({OpJal, 26'h020_0000}, 1'b0);
        for (int k = 3; k >= 0; k--) begin
            gapCycles(k);
            sendInstr(iType(OpAddi, 31, 7, 16'h0000), 1'b0);  // last one reads link
        end
        sendInstr(iType(OpOri, 0, 5, 16'h2468), 1'b0);
        sendInstr(rType(FnJr, 5, 0, 0, 0), 1'b0);             // forwarded rs
        for (int k = 0; k < 4; k++) begin
            sendInstr(iType(OpAddi, 6, 6, 16'h0001), 1'b0);
        end
        finishTest("jumps");

        // flush drops its instr and ends a pending shadow
        sendInstr({OpJ, 26'h000_1234}, 1'b0);
        sendInstr(iType(OpAddi, 6, 8, 16'h0011), 1'b1);
        sendInstr(iType(OpAddi, 6, 9, 16'h0022), 1'b0);
        for (int n = 0; n < RandomCount; n++) begin
            sendInstr(randomInstr(), ($urandom_range(11, 0) == 0));
            gapCycles($urandom_range(2, 0));
        end
        finishTest("random stream");

        gapCycles(4);
        @(negedge Clk);
        $display("tests %0d, checks %0d, errors %0d", testNum - 1, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/mipsPkg.sv
hdl/controlDecoder.sv
hdl/registerFile.sv
hdl/idExRegister.sv
hdl/executeUnit.sv
hdl/decodeExecute.sv
tb/resultChecker.sv
tb/tbDecodeExecute.sv

// File: Makefile
# Verilator build and run for the decode/execute testbench

VERILATOR ?= verilator
TOP       ?= tbDecodeExecute
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
